//--- Bender.yml
package:
  name: gb_cpu

sources:
  - logic/gb_cpu_common_pkg.sv
  - logic/gb_cpu_decoder_pkg.sv
  - logic/gb_cpu_alu.sv
  - logic/gb_cpu_fetch.sv
  - logic/gb_cpu_decoder.sv
  - logic/gb_cpu_execute.sv
  - logic/gb_cpu_top.sv
  - target: test
    files:
      - dv/gb_cpu_tb.sv

//--- dv/gb_cpu_tb.sv
module gb_cpu_tb
    import gb_cpu_common_pkg::*;
();

    typedef struct packed {
        retire_kind_t kind;
        logic         wr;
        logic [2:0]   dst;
        logic [7:0]   value;
        flags_t       flags;
        logic         ime;
        logic         halted;
        logic [31:0]  cycle;
    } exp_t;

    logic       clk;
    logic       arst_n;
    logic [7:0] byte_in;
    logic       byte_valid;
    logic       irq;
    logic       retire_valid;
    retire_t    retire;
    logic       ime;
    logic       halted;

    logic [7:0] m_regs [8];                           // reference register file
    flags_t     m_flags;
    logic       m_ime;
    logic       m_halted;
    exp_t       nxt;
    exp_t       expq [$];
    exp_t       got_e;
    integer     seed = 85833;
    int         cyc;

    gb_cpu_top uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .byte_in     (byte_in),
        .byte_valid  (byte_valid),
        .irq         (irq),
        .retire_valid(retire_valid),
        .retire      (retire),
        .ime         (ime),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    //////////////////////////////
    // checking
    //////////////////////////////

    task automatic die(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && retire_valid) begin
            if (expq.size() == 0)
                die("retire pulse with no instruction outstanding");
            got_e = expq.pop_front();
            check("retire cycle", cyc, got_e.cycle);       // two cycle latency
            check("retire.kind", retire.kind, got_e.kind);
            check("retire.flags", retire.flags, got_e.flags);
            check("ime", ime, got_e.ime);
            check("halted", halted, got_e.halted);
            check("retire.wrote_reg", retire.wrote_reg, got_e.wr);
            if (got_e.wr) begin
                check("retire.dst", retire.dst, got_e.dst);
                check("retire.value", retire.value, got_e.value);
            end
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic void set_reg(input int x, input logic [7:0] v);
        m_regs[x] = v;
        nxt.wr    = 1'b1;
        nxt.dst   = 3'(x);
        nxt.value = v;
    endfunction

    function automatic void alu8(input logic [2:0] o, input logic [7:0] b);
        logic [7:0] a;
        logic       cin;
        logic [8:0] s;
        logic [4:0] hs;
        a   = m_regs[7];
        cin = (o == 1 || o == 3) && m_flags.c;
        case (o)
            0, 1: begin
                s       = {1'b0, a} + {1'b0, b} + cin;
                hs      = {1'b0, a[3:0]} + {1'b0, b[3:0]} + cin;
                m_flags = '{s[7:0] == 0, 1'b0, hs[4], s[8]};
            end
            2, 3, 7: begin
                s       = {1'b0, a} - {1'b0, b} - cin;
                hs      = {1'b0, a[3:0]} - {1'b0, b[3:0]} - cin;
                m_flags = '{s[7:0] == 0, 1'b1, hs[4], s[8]};
            end
            4: begin
                s       = {1'b0, a & b};
                m_flags = '{s[7:0] == 0, 1'b0, 1'b1, 1'b0};
            end
            5: begin
                s       = {1'b0, a ^ b};
                m_flags = '{s[7:0] == 0, 1'b0, 1'b0, 1'b0};
            end
            default: begin
                s       = {1'b0, a | b};
                m_flags = '{s[7:0] == 0, 1'b0, 1'b0, 1'b0};
            end
        endcase
        if (o != 7)
            set_reg(7, s[7:0]);                       // cp keeps a
    endfunction

    function automatic void model_step(input logic [7:0] op, input logic cb,
                                       input logic [7:0] imm);
        int         x;
        int         y;
        logic [7:0] a;
        logic [7:0] r;
        logic       c;
        nxt  = '0;
        nxt.kind = NORMAL;
        x = op[2:0];
        y = op[5:3];
        c = 1'b0;
        if (cb) begin
            a = m_regs[x];
            if (x == 6) begin
                nxt.kind = ILLEGAL;
            end else if (op[7:6] == 2'b00) begin
                case (y)
                    0: {c, r} = {a, a[7]};
                    1: {r, c} = {a[0], a};
                    2: {c, r} = {a, m_flags.c};
                    3: {r, c} = {m_flags.c, a};
                    4: {c, r} = {a, 1'b0};
                    5: {r, c} = {a[7], a};
                    6: r = {a[3:0], a[7:4]};
                    default: {r, c} = {1'b0, a};
                endcase
                m_flags = '{r == 0, 1'b0, 1'b0, c};
                set_reg(x, r);
            end else if (op[7:6] == 2'b01) begin
                m_flags = '{~a[y], 1'b0, 1'b1, m_flags.c};
            end else if (op[7:6] == 2'b10) begin
                set_reg(x, a & ~(8'h01 << y));
            end else begin
                set_reg(x, a | (8'h01 << y));
            end
        end else if (op == 8'h00) begin
        end else if (op == 8'h76) begin
            m_halted = 1'b1;
        end else if (op == 8'hF3 || op == 8'hFB) begin
            m_ime = (op == 8'hFB);
        end else if (op[7:6] == 2'b01) begin
            if (x == 6 || y == 6)
                nxt.kind = ILLEGAL;
            else
                set_reg(y, m_regs[x]);
        end else if (op[7:6] == 2'b00 && x == 6) begin
            if (y == 6)
                nxt.kind = ILLEGAL;
            else
                set_reg(y, imm);
        end else if (op[7:6] == 2'b10) begin
            if (x == 6)
                nxt.kind = ILLEGAL;
            else
                alu8(y, m_regs[x]);
        end else if (op[7:6] == 2'b11 && x == 6) begin
            alu8(y, imm);
        end else if (op[7:6] == 2'b00 && (x == 4 || x == 5) && y != 6) begin
            a = m_regs[y];
            r = (x == 4) ? a + 8'd1 : a - 8'd1;
            m_flags = '{r == 0, x == 5, (x == 4) ? a[3:0] == 4'hF : a[3:0] == 4'h0,
                        m_flags.c};
            set_reg(y, r);
        end else if (op == 8'h2F) begin
            set_reg(7, ~m_regs[7]);
            m_flags.n = 1'b1;
            m_flags.h = 1'b1;
        end else if (op == 8'h37 || op == 8'h3F) begin
            m_flags = '{m_flags.z, 1'b0, 1'b0, (op == 8'h37) ? 1'b1 : ~m_flags.c};
        end else if (op[7:5] == 3'b000 && x == 7) begin
            a = m_regs[7];
            case (op[4:3])
                0: {c, r} = {a, a[7]};
                1: {r, c} = {a[0], a};
                2: {c, r} = {a, m_flags.c};
                default: {r, c} = {m_flags.c, a};
            endcase
            m_flags = '{1'b0, 1'b0, 1'b0, c};         // z always clear here
            set_reg(7, r);
        end else begin
            nxt.kind = ILLEGAL;
        end
        nxt.flags  = m_flags;
        nxt.ime    = m_ime;
        nxt.halted = m_halted;
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        #1;
        byte_in    = b;
        byte_valid = 1'b1;
    endtask

    // bytes go out in consecutive cycles until idle is called
    task automatic push(input logic [7:0] op, input logic cb = 1'b0,
                        input logic [7:0] imm = 8'h00);
        if (cb)
            send_byte(8'hCB);
        send_byte(op);
        if (!cb && op[2:0] == 3'b110 && (op[7:6] == 2'b00 || op[7:6] == 2'b11))
            send_byte(imm);
        model_step(op, cb, imm);
        nxt.cycle = cyc + 2;
        expq.push_back(nxt);
    endtask

    // entry slot is issued at the edge after irq rises
    task automatic expect_isr();
        m_ime      = 1'b0;
        m_halted   = 1'b0;
        nxt        = '0;
        nxt.kind   = ISR;
        nxt.flags  = m_flags;
        nxt.ime    = m_ime;
        nxt.halted = m_halted;
        nxt.cycle  = cyc + 2;
        expq.push_back(nxt);
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        byte_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (expq.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > 100)
                die("timeout waiting for retire_valid");
        end
    endtask

    task automatic settle();
        idle();
        drain();
    endtask

    task automatic load_random(input int r);
        push(8'h06 | (r << 3), 1'b0, $random(seed));
    endtask

    task automatic test_loads();
        for (int r = 0; r < 8; r++)
            if (r != 6) load_random(r);
        for (int d = 0; d < 8; d++)
            for (int s = 0; s < 8; s++)
                if (d != 6 && s != 6) push(8'h40 | (d << 3) | s);
        settle();
    endtask

    task automatic test_alu();
        int o;
        int s;
        repeat (24) begin
            o = $unsigned($random(seed)) % 8;
            s = $unsigned($random(seed)) % 8;
            if (s == 6) s = 0;
            load_random(7);
            load_random(s);
            push(8'h80 | (o << 3) | s);
            push(8'hC6 | (o << 3), 1'b0, $random(seed));
            push(8'h04 | (s << 3));
            push(8'h05 | (s << 3));
            push(8'h2F);
            push(($random(seed) & 1) ? 8'h37 : 8'h3F);
            settle();
        end
    endtask

    task automatic test_shifts();
        push(8'h3E, 1'b0, 8'h00);                    // zero result with z cleared
        push(8'h37);
        push(8'h3F);
        push(8'h17);
        push(8'h07);
        repeat (40) begin
            load_random($unsigned($random(seed)) % 6);
            load_random(7);
            push($random(seed), 1'b1);
            push(8'h07 | ((($unsigned($random(seed)) % 4)) << 3));
        end
        settle();
    endtask

    task automatic test_stream();
        logic [7:0] op;
        repeat (60) begin
            op = $random(seed);
            if (op == 8'hCB)
                push($random(seed), 1'b1);
            else if (op != 8'h76)
                push(op, 1'b0, $random(seed));
        end
        settle();
    endtask

    task automatic test_illegal();
        logic [7:0] ops [7];
        ops = '{8'h7E, 8'h70, 8'h34, 8'h86, 8'h01, 8'hC3, 8'h36};
        for (int i = 0; i < 7; i++)
            push(ops[i], 1'b0, 8'h5A);
        push(8'h06, 1'b1);                            // rlc [hl]
        for (int r = 7; r >= 0; r--)
            if (r != 6) push(8'h78 | r);
        settle();
    endtask

    task automatic test_irq();
        push(8'hF3);
        settle();
        @(posedge clk);
        #1;
        irq = 1'b1;
        repeat (10) @(posedge clk);                   // any retire here is caught
        #1;
        irq = 1'b0;
        push(8'hFB);
        push(8'h76);
        settle();
        send_byte(8'h3C);                             // dropped while halted
        idle();
        repeat (6) @(posedge clk);
        #1;
        irq = 1'b1;
        expect_isr();
        drain();
        irq = 1'b0;
        push(8'hFB);
        settle();
        @(posedge clk);
        #1;
        irq = 1'b1;
        expect_isr();
        drain();
        irq = 1'b0;
        push(8'h78);
        settle();
    endtask

    initial begin
        arst_n     = 1'b0;
        byte_in    = 8'h00;
        byte_valid = 1'b0;
        irq        = 1'b0;
        cyc        = 0;
        m_flags    = '0;
        m_ime      = 1'b0;
        m_halted   = 1'b0;
        for (int i = 0; i < 8; i++) m_regs[i] = 8'h00;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_loads();
        test_alu();
        test_shifts();
        test_stream();
        test_illegal();
        test_irq();
        repeat (4) @(posedge clk);
        if (expq.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            die("instructions still outstanding at end of run");
        end
    end

endmodule

//--- list.f
logic/gb_cpu_common_pkg.sv
logic/gb_cpu_decoder_pkg.sv
logic/gb_cpu_alu.sv
logic/gb_cpu_fetch.sv
logic/gb_cpu_decoder.sv
logic/gb_cpu_execute.sv
logic/gb_cpu_top.sv
dv/gb_cpu_tb.sv

//--- logic/gb_cpu_alu.sv
module gb_cpu_alu
    import gb_cpu_common_pkg::*;
(
    input  alu_op_t    op,
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic [2:0] bit_sel,
    input  flags_t     flags_in,
    output logic [7:0] result,
    output flags_t     flags_out
);

    logic [8:0] sum;
    logic [4:0] half;
    logic       cin;
    logic       carry;
    logic       shift_op;

    assign shift_op = op inside {RLCA, RRCA, RLA, RRA, RLC, RRC, RL, RR, SLA, SRA, SWAP, SRL};

    always_comb begin
        result    = a;
        flags_out = flags_in;
        cin       = (op == ADC || op == SBC) && flags_in.c;
        sum       = '0;
        half      = '0;
        carry     = 1'b0;
        unique case (op)
            ADD, ADC: begin
                sum       = {1'b0, a} + {1'b0, b} + 9'(cin);
                half      = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(cin); // carry out of bit 3
                result    = sum[7:0];
                flags_out = '{z: sum[7:0] == 8'h00, n: 1'b0, h: half[4], c: sum[8]};
            end
            SUB, SBC, CP: begin
                sum       = {1'b0, a} - {1'b0, b} - 9'(cin);
                half      = {1'b0, a[3:0]} - {1'b0, b[3:0]} - 5'(cin); // borrow from bit 4
                result    = sum[7:0];
                flags_out = '{z: sum[7:0] == 8'h00, n: 1'b1, h: half[4], c: sum[8]};
            end
            AND: begin
                result    = a & b;
                flags_out = '{z: result == 8'h00, n: 1'b0, h: 1'b1, c: 1'b0};
            end
            XOR, OR: begin
                result    = (op == XOR) ? a ^ b : a | b;
                flags_out = '{z: result == 8'h00, n: 1'b0, h: 1'b0, c: 1'b0};
            end
            INC: begin
                result    = a + 8'd1;
                flags_out = '{z: result == 8'h00, n: 1'b0, h: a[3:0] == 4'hF, c: flags_in.c};
            end
            DEC: begin
                result    = a - 8'd1;
                flags_out = '{z: result == 8'h00, n: 1'b1, h: a[3:0] == 4'h0, c: flags_in.c};
            end
            CPL: begin
                result      = ~a;
                flags_out.n = 1'b1;
                flags_out.h = 1'b1;
            end
            SCF: flags_out = '{z: flags_in.z, n: 1'b0, h: 1'b0, c: 1'b1};
            CCF: flags_out = '{z: flags_in.z, n: 1'b0, h: 1'b0, c: ~flags_in.c};

            RLCA, RLC: {carry, result} = {a, a[7]};
            RRCA, RRC: {result, carry} = {a[0], a};
            RLA, RL:   {carry, result} = {a, flags_in.c};       // through carry
            RRA, RR:   {result, carry} = {flags_in.c, a};
            SLA:       {carry, result} = {a, 1'b0};
            SRA:       {result, carry} = {a[7], a};             // sign kept
            SRL:       {result, carry} = {1'b0, a};
            SWAP:      result = {a[3:0], a[7:4]};

            BIT:  flags_out = '{z: ~a[bit_sel], n: 1'b0, h: 1'b1, c: flags_in.c};
            RES:  result = a & ~(8'h01 << bit_sel);
            SET:  result = a | (8'h01 << bit_sel);
            PASS: result = b;
            default: ;
        endcase

        if (shift_op) begin
            // accumulator forms always clear z
            flags_out = '{z: !(op inside {RLCA, RRCA, RLA, RRA}) && result == 8'h00,
                          n: 1'b0, h: 1'b0, c: carry};
        end
    end

endmodule

//--- logic/gb_cpu_common_pkg.sv
package gb_cpu_common_pkg;

    //////////////////////////////
    // register and flag encodings
    //////////////////////////////

    typedef enum logic [2:0] {
        B, C, D, E, H, L, HL_IND, A                  // sm83 r8 field order
    } opcode_r8_t;

    typedef enum logic [4:0] {
        ADD, ADC, SUB, SBC, AND, XOR, OR, CP,        // same order as opcode[5:3]
        INC, DEC, CPL, SCF, CCF,
        RLCA, RRCA, RLA, RRA,                        // same order as opcode[4:3]
        RLC, RRC, RL, RR, SLA, SRA, SWAP, SRL,       // cb group, opcode[5:3]
        BIT, RES, SET,
        PASS
    } alu_op_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    //////////////////////////////
    // pipeline records
    //////////////////////////////

    typedef struct packed {
        logic [7:0] opcode;
        logic       cb_prefix;
        logic [7:0] imm8;
        logic       isr;                             // interrupt entry slot
    } instr_t;

    typedef struct packed {
        alu_op_t    alu_op;
        opcode_r8_t dst;
        opcode_r8_t src;
        logic       use_imm;                         // b operand from imm8
        logic [2:0] bit_sel;
        logic       write_reg;
        logic       write_flags;
        logic       halt;
        logic       di;
        logic       ei;
        logic       isr;
        logic       illegal;
    } schedule_t;

    typedef enum logic [1:0] {
        NORMAL, ILLEGAL, ISR
    } retire_kind_t;

    typedef struct packed {
        retire_kind_t kind;
        opcode_r8_t   dst;
        logic [7:0]   value;
        logic         wrote_reg;
        flags_t       flags;                         // flags after the instruction
    } retire_t;

endpackage

//--- logic/gb_cpu_decoder.sv
module gb_cpu_decoder
    import gb_cpu_common_pkg::*;
    import gb_cpu_decoder_pkg::*;
(
    input  instr_t    instr,
    output schedule_t schedule
);

    logic [7:0] op;
    opcode_r8_t r_lo;
    opcode_r8_t r_hi;

    assign op   = instr.opcode;
    assign r_lo = opcode_r8_t'(op[2:0]);
    assign r_hi = opcode_r8_t'(op[5:3]);

    always_comb begin
        schedule = empty_schedule();
        if (instr.isr) begin
            schedule = isr_schedule();
        end else if (instr.cb_prefix) begin
            case (op) inside
                8'b00_???_???: schedule = alu_schedule(alu_op_t'(RLC + op[5:3]), r_lo, r_lo);
                8'b01_???_???: schedule = alu_schedule(BIT, r_lo, r_lo, 1'b0, op[5:3], 1'b0);
                8'b10_???_???: schedule = alu_schedule(RES, r_lo, r_lo, 1'b0, op[5:3], 1'b1,
                                                       1'b0);
                8'b11_???_???: schedule = alu_schedule(SET, r_lo, r_lo, 1'b0, op[5:3], 1'b1,
                                                       1'b0);
                default: ;
            endcase
        end else begin
            case (op) inside
                //////////////////////////////
                // misc, ahead of the ld block
                //////////////////////////////
                OPC_NOP:  schedule = misc_schedule();
                OPC_HALT: schedule = misc_schedule(.halt(1'b1)); // sits inside 01_xxx_xxx
                OPC_DI:   schedule = misc_schedule(.di(1'b1));
                OPC_EI:   schedule = misc_schedule(.ei(1'b1));

                8'b01_???_???: schedule = load_schedule(r_hi, r_lo);              // ld r8, r8
                8'b00_???_110: schedule = load_schedule(r_hi, A, .use_imm(1'b1)); // ld r8, imm8

                //////////////////////////////
                // 8 bit arithmetic
                //////////////////////////////
                8'b10_???_???: schedule = alu_schedule(alu_op_t'({2'b00, op[5:3]}), A, r_lo,
                                                       .write_reg(op[5:3] != 3'b111));
                8'b11_???_110: schedule = alu_schedule(alu_op_t'({2'b00, op[5:3]}), A, A,
                                                       .use_imm(1'b1),
                                                       .write_reg(op[5:3] != 3'b111));
                8'b00_???_100: schedule = alu_schedule(INC, r_hi, r_hi);
                8'b00_???_101: schedule = alu_schedule(DEC, r_hi, r_hi);
                8'h2F:         schedule = alu_schedule(CPL, A, A);
                8'h37:         schedule = alu_schedule(SCF, A, A, .write_reg(1'b0));
                8'h3F:         schedule = alu_schedule(CCF, A, A, .write_reg(1'b0));
                8'b000_??_111: schedule = alu_schedule(alu_op_t'(RLCA + op[4:3]), A, A);

                default: schedule = empty_schedule();  // memory, 16 bit, jumps, daa, stop
            endcase
        end
    end

endmodule

//--- logic/gb_cpu_decoder_pkg.sv
package gb_cpu_decoder_pkg;

    import gb_cpu_common_pkg::*;

    localparam logic [7:0] CB_PREFIX_BYTE = 8'hCB;
    localparam logic [7:0] OPC_HALT       = 8'h76;
    localparam logic [7:0] OPC_DI         = 8'hF3;
    localparam logic [7:0] OPC_EI         = 8'hFB;
    localparam logic [7:0] OPC_NOP        = 8'h00;

    // ld r8/[hl], imm8 is 00_rrr_110, alu imm8 is 11_ooo_110
    function automatic logic takes_imm8(input logic [7:0] opcode);
        return (opcode[2:0] == 3'b110) && (opcode[7:6] == 2'b00 || opcode[7:6] == 2'b11);
    endfunction

    //////////////////////////////
    // schedule builders
    //////////////////////////////

    // anything not built below stays an illegal no-effect slot
    function automatic schedule_t empty_schedule();
        schedule_t s;
        s         = '0;
        s.alu_op  = PASS;
        s.dst     = A;
        s.src     = A;
        s.illegal = 1'b1;
        return s;
    endfunction

    function automatic schedule_t alu_schedule(
        input alu_op_t    op,
        input opcode_r8_t dst,
        input opcode_r8_t src,
        input logic       use_imm     = 1'b0,
        input logic [2:0] bit_sel     = 3'd0,
        input logic       write_reg   = 1'b1,
        input logic       write_flags = 1'b1
    );
        schedule_t s;
        s             = empty_schedule();
        s.alu_op      = op;
        s.dst         = dst;
        s.src         = src;
        s.use_imm     = use_imm;
        s.bit_sel     = bit_sel;
        s.write_reg   = write_reg;
        s.write_flags = write_flags;
        s.illegal     = (dst == HL_IND) || (!use_imm && src == HL_IND); // no memory port
        return s;
    endfunction

    function automatic schedule_t load_schedule(
        input opcode_r8_t dst,
        input opcode_r8_t src,
        input logic       use_imm = 1'b0
    );
        return alu_schedule(PASS, dst, src, use_imm, 3'd0, 1'b1, 1'b0); // loads keep flags
    endfunction

    function automatic schedule_t misc_schedule(
        input logic halt = 1'b0,
        input logic di   = 1'b0,
        input logic ei   = 1'b0
    );
        schedule_t s;
        s         = empty_schedule();
        s.halt    = halt;
        s.di      = di;
        s.ei      = ei;
        s.illegal = 1'b0;
        return s;
    endfunction

    function automatic schedule_t isr_schedule();
        schedule_t s;
        s         = empty_schedule();
        s.isr     = 1'b1;
        s.illegal = 1'b0;
        return s;
    endfunction

endpackage

//--- logic/gb_cpu_execute.sv
module gb_cpu_execute
    import gb_cpu_common_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  schedule_t  schedule,
    input  logic       instr_valid,
    input  logic [7:0] imm8,
    output retire_t    retire,
    output logic       retire_valid,
    output logic       ime,
    output logic       halted
);

    logic [7:0] regs [8];                            // indexed by opcode_r8_t, slot 6 unused
    flags_t     flags;
    logic [7:0] alu_a;
    logic [7:0] alu_b;
    logic [7:0] alu_result;
    flags_t     alu_flags;
    logic       commit;

    assign alu_a  = regs[schedule.dst];
    assign alu_b  = schedule.use_imm ? imm8 : regs[schedule.src];
    assign commit = instr_valid && !schedule.illegal;

    gb_cpu_alu u_alu (
        .op       (schedule.alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .bit_sel  (schedule.bit_sel),
        .flags_in (flags),
        .result   (alu_result),
        .flags_out(alu_flags)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) regs[i] <= 8'h00;
            flags        <= '0;
            ime          <= 1'b0;
            halted       <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= instr_valid;
            if (commit) begin
                if (schedule.write_reg)
                    regs[schedule.dst] <= alu_result;
                if (schedule.write_flags)
                    flags <= alu_flags;
                if (schedule.ei)
                    ime <= 1'b1;
                else if (schedule.di || schedule.isr)
                    ime <= 1'b0;                     // entry masks further interrupts
                if (schedule.halt)
                    halted <= 1'b1;
                else if (schedule.isr)
                    halted <= 1'b0;                  // wake up
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            retire.kind      <= schedule.illegal ? ILLEGAL : (schedule.isr ? ISR : NORMAL);
            retire.dst       <= schedule.dst;
            retire.value     <= alu_result;
            retire.wrote_reg <= schedule.write_reg && !schedule.illegal;
            retire.flags     <= (schedule.write_flags && !schedule.illegal) ? alu_flags : flags;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) retire_valid == $past(instr_valid))
        else $error("retire pulse out of step with instr_valid");

endmodule

//--- logic/gb_cpu_fetch.sv
module gb_cpu_fetch
    import gb_cpu_common_pkg::*;
    import gb_cpu_decoder_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [7:0] byte_in,
    input  logic       byte_valid,
    input  logic       irq,
    input  logic       ime,
    input  logic       halted,
    output instr_t     instr,
    output logic       instr_valid
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_CB,
        WAIT_IMM
    } fetch_state_t;

    fetch_state_t state;
    logic         byte_take;
    logic         isr_take;

    assign byte_take = byte_valid && !halted;                    // halt blocks the byte stream
    // ime is stale while an instruction sits in front of execute
    assign isr_take  = irq && ime && state == IDLE && !instr_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b0;
            if (isr_take) begin
                instr_valid <= 1'b1;
            end else if (byte_take) begin
                unique case (state)
                    IDLE: begin
                        if (byte_in == CB_PREFIX_BYTE)
                            state <= WAIT_CB;
                        else if (takes_imm8(byte_in))
                            state <= WAIT_IMM;
                        else
                            instr_valid <= 1'b1;         // single byte instruction
                    end
                    WAIT_CB, WAIT_IMM: begin
                        state       <= IDLE;
                        instr_valid <= 1'b1;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (isr_take) begin
            instr.opcode    <= OPC_NOP;
            instr.cb_prefix <= 1'b0;
            instr.isr       <= 1'b1;
        end else if (byte_take) begin
            case (state)
                IDLE: begin
                    instr.opcode    <= byte_in;
                    instr.cb_prefix <= 1'b0;
                    instr.isr       <= 1'b0;
                end
                WAIT_CB: begin
                    instr.opcode    <= byte_in;
                    instr.cb_prefix <= 1'b1;
                end
                WAIT_IMM: instr.imm8 <= byte_in;
                default: ;
            endcase
        end
    end

    // back to back instructions each need a fresh byte or an entry slot
    assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid && $past(instr_valid) |-> $past(byte_valid) && $past(byte_valid || isr_take, 2));

    assert property (@(posedge clk) disable iff (!arst_n) isr_take |-> !byte_valid)
        else $error("byte_valid during interrupt entry, byte dropped");

endmodule

//--- logic/gb_cpu_top.sv
module gb_cpu_top
    import gb_cpu_common_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [7:0] byte_in,
    input  logic       byte_valid,
    input  logic       irq,
    output logic       retire_valid,
    output retire_t    retire,
    output logic       ime,
    output logic       halted
);

    instr_t    instr;
    logic      instr_valid;
    schedule_t schedule;

    gb_cpu_fetch u_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .byte_in    (byte_in),
        .byte_valid (byte_valid),
        .irq        (irq),
        .ime        (ime),
        .halted     (halted),
        .instr      (instr),
        .instr_valid(instr_valid)
    );

    gb_cpu_decoder u_decoder (
        .instr   (instr),
        .schedule(schedule)
    );

    gb_cpu_execute u_execute (
        .clk         (clk),
        .arst_n      (arst_n),
        .schedule    (schedule),
        .instr_valid (instr_valid),
        .imm8        (instr.imm8),
        .retire      (retire),
        .retire_valid(retire_valid),
        .ime         (ime),
        .halted      (halted)
    );

endmodule
